// File: verilog/gomoku_consts.svh
`ifndef GOMOKU_CONSTS_SVH
`define GOMOKU_CONSTS_SVH

// board geometry
`define BOARD_N     15
`define CELLS       225
`define COORD_W     5

// line lengths
`define WIN_LEN     5
`define THREAT_LEN  4
`define LINE_DIRS   4

// threat list
`define MAX_CAND    16
`define CAND_IDX_W  4
`define CAND_CNT_W  5

`endif

// File: verilog/board_pkg.sv
`include "gomoku_consts.svh"

package board_pkg;

    typedef enum logic [1:0] {
        EMPTY  = 2'd0,
        OURS   = 2'd1,
        THEIRS = 2'd2
    } cell_t;

    typedef logic [`COORD_W-1:0] coord_t;

    // row-major, element row * BOARD_N + col
    typedef cell_t [`CELLS-1:0] board_t;

    function automatic int cell_idx(input coord_t row, input coord_t col);
        return int'(row) * `BOARD_N + int'(col);
    endfunction

    // equal stones stepping away from (row, col), centre not counted
    function automatic int ray_len(input board_t b, input coord_t row, input coord_t col,
                                   input int dr, input int dc, input cell_t stone);
        int   n;
        int   r;
        int   c;
        logic run_on;
        n = 0;
        run_on = 1'b1;
        for (int k = 1; k < `WIN_LEN; k++) begin
            r = int'(row) + k * dr;
            c = int'(col) + k * dc;
            if (r < 0 || r >= `BOARD_N || c < 0 || c >= `BOARD_N) begin
                run_on = 1'b0;
            end else if (b[r * `BOARD_N + c] != stone) begin
                run_on = 1'b0;
            end
            if (run_on) begin
                n++;
            end
        end
        return n;
    endfunction

    // 0 horizontal, 1 vertical, 2 down-right, 3 down-left
    function automatic int line_len(input board_t b, input coord_t row, input coord_t col,
                                    input logic [1:0] dir, input cell_t stone);
        int dr;
        int dc;
        case (dir)
            2'd0: begin
                dr = 0;
                dc = 1;
            end
            2'd1: begin
                dr = 1;
                dc = 0;
            end
            2'd2: begin
                dr = 1;
                dc = 1;
            end
            default: begin
                dr = 1;
                dc = -1;
            end
        endcase
        return 1 + ray_len(b, row, col, dr, dc, stone) + ray_len(b, row, col, -dr, -dc, stone);
    endfunction

endpackage

// File: verilog/search_pkg.sv
`include "gomoku_consts.svh"

package search_pkg;

    // bit 0 of the depth maps straight onto the mover
    typedef enum logic {
        SIDE_THEM = 1'b0,
        SIDE_US   = 1'b1
    } side_t;

    typedef enum logic [2:0] {
        IDLE,
        SEARCH,
        ISSUE,
        WAIT_CHILD,
        DONE
    } node_state_t;

    typedef struct packed {
        board_pkg::coord_t row;
        board_pkg::coord_t col;
    } cand_t;

    function automatic board_pkg::cell_t mover_cell(input side_t side);
        return (side == SIDE_US) ? board_pkg::OURS : board_pkg::THEIRS;
    endfunction

endpackage

// File: verilog/board_if.sv
`include "gomoku_consts.svh"

interface board_if;

    logic                start;
    search_pkg::side_t   side;
    board_pkg::board_t   board;
    search_pkg::cand_t   last;

    // node controller side
    modport ctrl (
        output start,
        output side,
        output board,
        output last
    );

    // win checker and threat scanner
    modport eng (
        input start,
        input side,
        input board,
        input last
    );

endinterface

// File: verilog/win_check.sv
`include "gomoku_consts.svh"

module win_check (
    input  logic              i_clk,
    input  logic              i_rst_n,
    board_if.eng              bus,
    output logic              o_done,
    output logic              o_found,
    output search_pkg::side_t o_winner
);

    logic              busy_r;
    logic [1:0]        dir_r;
    logic              found_r;
    logic              done_r;
    search_pkg::side_t winner_r;

    board_pkg::cell_t  stone;
    logic              active;
    logic              hit;

    assign stone  = bus.board[board_pkg::cell_idx(bus.last.row, bus.last.col)];
    assign active = bus.start | busy_r;

    // direction 0 is checked in the start cycle itself
    assign hit = (stone != board_pkg::EMPTY) &&
                 (board_pkg::line_len(bus.board, bus.last.row, bus.last.col, dir_r, stone)
                  >= `WIN_LEN);

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_r   <= 1'b0;
            dir_r    <= 2'd0;
            found_r  <= 1'b0;
            done_r   <= 1'b0;
            winner_r <= search_pkg::SIDE_THEM;
        end else begin
            done_r <= 1'b0;
            if (bus.start) begin
                winner_r <= (stone == board_pkg::OURS) ? search_pkg::SIDE_US
                                                       : search_pkg::SIDE_THEM;
            end
            if (active) begin
                found_r <= (bus.start ? 1'b0 : found_r) | hit;
                if (dir_r == 2'(`LINE_DIRS - 1)) begin
                    busy_r <= 1'b0;
                    dir_r  <= 2'd0;
                    done_r <= 1'b1;
                end else begin
                    busy_r <= 1'b1;
                    dir_r  <= dir_r + 2'd1;
                end
            end
        end
    end

    assign o_done   = done_r;
    assign o_found  = found_r;
    assign o_winner = winner_r;

    // controller must hand over a board that holds the last move
    a_last_move_stone: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        bus.start |-> stone != board_pkg::EMPTY);

endmodule

// File: verilog/threat_scan.sv
`include "gomoku_consts.svh"

module threat_scan (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    board_if.eng                   bus,
    input  logic [`CAND_IDX_W-1:0] i_rd_idx,
    output logic                   o_done,
    output logic [`CAND_CNT_W-1:0] o_count,
    output search_pkg::cand_t      o_rd_cand
);

    search_pkg::cand_t      list_r [`MAX_CAND];
    logic                   busy_r;
    logic                   done_r;
    logic [`CAND_CNT_W-1:0] count_r;
    board_pkg::coord_t      row_r;
    board_pkg::coord_t      col_r;

    board_pkg::cell_t       mover;
    logic                   hit;
    logic                   keep;
    logic                   last_col;
    logic                   last_cell;

    assign mover     = search_pkg::mover_cell(bus.side);
    assign last_col  = (col_r == `BOARD_N - 1);
    assign last_cell = last_col && (row_r == `BOARD_N - 1);

    // empty cell where the mover's stone would make four or more
    always_comb begin
        hit = 1'b0;
        if (bus.board[board_pkg::cell_idx(row_r, col_r)] == board_pkg::EMPTY) begin
            for (int d = 0; d < `LINE_DIRS; d++) begin
                if (board_pkg::line_len(bus.board, row_r, col_r, 2'(d), mover)
                    >= `THREAT_LEN) begin
                    hit = 1'b1;
                end
            end
        end
    end

    // hits past capacity are dropped
    assign keep = busy_r && hit && (count_r < `MAX_CAND);

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_r  <= 1'b0;
            done_r  <= 1'b0;
            count_r <= '0;
            row_r   <= '0;
            col_r   <= '0;
        end else begin
            done_r <= 1'b0;
            if (bus.start) begin
                busy_r  <= 1'b1;
                count_r <= '0;
                row_r   <= '0;
                col_r   <= '0;
            end else if (busy_r) begin
                if (keep) begin
                    count_r <= count_r + 1'b1;
                end
                if (last_cell) begin
                    busy_r <= 1'b0;
                    done_r <= 1'b1;
                end else if (last_col) begin
                    col_r <= '0;
                    row_r <= row_r + 1'b1;
                end else begin
                    col_r <= col_r + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (keep) begin
            list_r[count_r[`CAND_IDX_W-1:0]] <= '{row: row_r, col: col_r};
        end
    end

    assign o_done    = done_r;
    assign o_count   = count_r;
    assign o_rd_cand = list_r[i_rd_idx];

    a_count_cap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        count_r <= `MAX_CAND);

    // board must stay put for the whole sweep
    a_no_restart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        busy_r |-> !bus.start);

endmodule

// File: verilog/kill_node.sv
`include "gomoku_consts.svh"

module kill_node (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  logic [4:0]             i_depth,
    input  board_pkg::board_t      i_board,
    input  board_pkg::coord_t      i_last_row,
    input  board_pkg::coord_t      i_last_col,
    input  logic                   i_child_done,
    input  logic                   i_child_result,
    input  logic                   i_win_done,
    input  logic                   i_win_found,
    input  search_pkg::side_t      i_win_winner,
    input  logic                   i_scan_done,
    input  logic [`CAND_CNT_W-1:0] i_scan_count,
    input  search_pkg::cand_t      i_rd_cand,
    board_if.ctrl                  bus,
    output logic [`CAND_IDX_W-1:0] o_rd_idx,
    output logic                   o_finish,
    output logic                   o_result,
    output logic                   o_child_start,
    output board_pkg::coord_t      o_child_row,
    output board_pkg::coord_t      o_child_col,
    output board_pkg::board_t      o_child_board
);

    search_pkg::node_state_t state_r;
    logic                    eng_start_r;
    logic                    win_seen_r;
    logic                    scan_seen_r;
    logic                    result_r;
    logic [`CAND_CNT_W-1:0]  idx_r;

    board_pkg::board_t       board_r;
    search_pkg::cand_t       last_r;
    search_pkg::side_t       side_r;
    board_pkg::coord_t       child_row_r;
    board_pkg::coord_t       child_col_r;
    board_pkg::board_t       child_board_r;

    logic                    both_done;
    logic                    stop;
    logic                    list_end;
    logic                    go_issue;
    board_pkg::board_t       child_board_w;

    assign both_done = (win_seen_r | i_win_done) & (scan_seen_r | i_scan_done);
    // first 1 decides for us, first 0 decides for them
    assign stop      = (i_child_result == (side_r == search_pkg::SIDE_US));
    assign list_end  = (idx_r == i_scan_count);
    assign go_issue  = (state_r == search_pkg::SEARCH && both_done && !i_win_found &&
                        i_scan_count != '0) ||
                       (state_r == search_pkg::WAIT_CHILD && i_child_done && !stop && !list_end);

    always_comb begin
        child_board_w = board_r;
        child_board_w[board_pkg::cell_idx(i_rd_cand.row, i_rd_cand.col)] =
            search_pkg::mover_cell(side_r);
    end

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= search_pkg::IDLE;
            eng_start_r <= 1'b0;
            win_seen_r  <= 1'b0;
            scan_seen_r <= 1'b0;
            result_r    <= 1'b0;
            idx_r       <= '0;
        end else begin
            eng_start_r <= 1'b0;
            if (i_win_done) begin
                win_seen_r <= 1'b1;
            end
            if (i_scan_done) begin
                scan_seen_r <= 1'b1;
            end
            case (state_r)
                search_pkg::IDLE: begin
                    if (i_start && i_depth == 5'd0) begin
                        result_r <= i_depth[0];
                        state_r  <= search_pkg::DONE;
                    end else if (i_start) begin
                        // verdict when nothing overturns it
                        result_r    <= ~i_depth[0];
                        eng_start_r <= 1'b1;
                        win_seen_r  <= 1'b0;
                        scan_seen_r <= 1'b0;
                        idx_r       <= '0;
                        state_r     <= search_pkg::SEARCH;
                    end
                end
                search_pkg::SEARCH: begin
                    if (both_done && i_win_found) begin
                        result_r <= (i_win_winner == search_pkg::SIDE_US);
                        state_r  <= search_pkg::DONE;
                    end else if (go_issue) begin
                        state_r <= search_pkg::ISSUE;
                    end else if (both_done) begin
                        state_r <= search_pkg::DONE;
                    end
                end
                search_pkg::ISSUE: begin
                    idx_r   <= idx_r + 1'b1;
                    state_r <= search_pkg::WAIT_CHILD;
                end
                search_pkg::WAIT_CHILD: begin
                    if (i_child_done && stop) begin
                        result_r <= i_child_result;
                        state_r  <= search_pkg::DONE;
                    end else if (go_issue) begin
                        state_r <= search_pkg::ISSUE;
                    end else if (i_child_done) begin
                        state_r <= search_pkg::DONE;
                    end
                end
                default: begin
                    state_r <= search_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == search_pkg::IDLE && i_start) begin
            board_r <= i_board;
            last_r  <= '{row: i_last_row, col: i_last_col};
            side_r  <= search_pkg::side_t'(i_depth[0]);
        end
        if (go_issue) begin
            child_row_r   <= i_rd_cand.row;
            child_col_r   <= i_rd_cand.col;
            child_board_r <= child_board_w;
        end
    end

    assign bus.start = eng_start_r;
    assign bus.side  = side_r;
    assign bus.board = board_r;
    assign bus.last  = last_r;

    assign o_rd_idx      = idx_r[`CAND_IDX_W-1:0];
    assign o_finish      = (state_r == search_pkg::DONE);
    assign o_result      = result_r;
    assign o_child_start = (state_r == search_pkg::ISSUE);
    assign o_child_row   = child_row_r;
    assign o_child_col   = child_col_r;
    assign o_child_board = child_board_r;

    // the child may only answer a request that is outstanding
    a_child_done_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_child_done |-> state_r == search_pkg::WAIT_CHILD);

endmodule

// File: verilog/gomoku_kill_top.sv
`include "gomoku_consts.svh"

module gomoku_kill_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  logic [4:0]        i_depth,
    input  board_pkg::board_t i_board,
    input  board_pkg::coord_t i_last_row,
    input  board_pkg::coord_t i_last_col,
    input  logic              i_child_done,
    input  logic              i_child_result,
    output logic              o_finish,
    output logic              o_result,
    output logic              o_child_start,
    output board_pkg::coord_t o_child_row,
    output board_pkg::coord_t o_child_col,
    output board_pkg::board_t o_child_board
);

    logic                   win_done;
    logic                   win_found;
    search_pkg::side_t      win_winner;
    logic                   scan_done;
    logic [`CAND_CNT_W-1:0] scan_count;
    logic [`CAND_IDX_W-1:0] rd_idx;
    search_pkg::cand_t      rd_cand;

    board_if bus_i ();

    kill_node node_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_depth        (i_depth),
        .i_board        (i_board),
        .i_last_row     (i_last_row),
        .i_last_col     (i_last_col),
        .i_child_done   (i_child_done),
        .i_child_result (i_child_result),
        .i_win_done     (win_done),
        .i_win_found    (win_found),
        .i_win_winner   (win_winner),
        .i_scan_done    (scan_done),
        .i_scan_count   (scan_count),
        .i_rd_cand      (rd_cand),
        .bus            (bus_i.ctrl),
        .o_rd_idx       (rd_idx),
        .o_finish       (o_finish),
        .o_result       (o_result),
        .o_child_start  (o_child_start),
        .o_child_row    (o_child_row),
        .o_child_col    (o_child_col),
        .o_child_board  (o_child_board)
    );

    win_check win_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .bus      (bus_i.eng),
        .o_done   (win_done),
        .o_found  (win_found),
        .o_winner (win_winner)
    );

    threat_scan scan_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .bus       (bus_i.eng),
        .i_rd_idx  (rd_idx),
        .o_done    (scan_done),
        .o_count   (scan_count),
        .o_rd_cand (rd_cand)
    );

endmodule

// File: bench/tb_gomoku_kill.sv
`include "gomoku_consts.svh"

module tb_gomoku_kill;

    timeunit 1ns;
    timeprecision 100ps;

    // start register, scan sweep, decision cycle
    localparam int NODE_LAT = 1 + (`CELLS + 1) + 1;
    // issue cycle, longest reply delay, answer cycle
    localparam int CHILD_MAX = 22;
    localparam int NODE_RUNS = 18;
    localparam int TIMEOUT_CYCLES = 16 + 32 +
                                    NODE_RUNS * (NODE_LAT + 2 + `MAX_CAND * CHILD_MAX);

    logic              i_clk;
    logic              i_rst_n;
    logic              i_start;
    logic [4:0]        i_depth;
    board_pkg::board_t i_board;
    board_pkg::coord_t i_last_row;
    board_pkg::coord_t i_last_col;
    logic              i_child_done;
    logic              i_child_result;
    logic              o_finish;
    logic              o_result;
    logic              o_child_start;
    board_pkg::coord_t o_child_row;
    board_pkg::coord_t o_child_col;
    board_pkg::board_t o_child_board;

    int                errors;
    int                cycle_cnt;
    board_pkg::board_t bd;
    bit                child_res [`MAX_CAND];

    // model results
    bit                mdl_win;
    bit                mdl_win_us;
    int                mdl_full;
    int                exp_row [$];
    int                exp_col [$];
    int                req_row [$];
    int                req_col [$];

    gomoku_kill_top dut_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_depth        (i_depth),
        .i_board        (i_board),
        .i_last_row     (i_last_row),
        .i_last_col     (i_last_col),
        .i_child_done   (i_child_done),
        .i_child_result (i_child_result),
        .o_finish       (o_finish),
        .o_result       (o_result),
        .o_child_start  (o_child_start),
        .o_child_row    (o_child_row),
        .o_child_col    (o_child_col),
        .o_child_board  (o_child_board)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not end within %0d cycles, errors so far %0d",
                 TIMEOUT_CYCLES, errors);
        $display("test failed");
        $finish;
    end

    task automatic step();
        @(posedge i_clk);
        #10;
    endtask

    task automatic check_eq(input logic [511:0] got, input logic [511:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic place(input int r, input int c, input board_pkg::cell_t s);
        bd[r * `BOARD_N + c] = s;
    endtask

    task automatic place_line(input int r, input int c, input int dr, input int dc,
                              input int len, input board_pkg::cell_t s);
        for (int k = 0; k < len; k++) begin
            place(r + k * dr, c + k * dc, s);
        end
    endtask

    // equal stones walking away from (r, c), at most four steps
    function automatic int count_ray(input board_pkg::board_t b, input int r, input int c,
                                     input int dr, input int dc, input board_pkg::cell_t s);
        int n;
        int rr;
        int cc;
        bit go;
        n = 0;
        go = 1'b1;
        for (int k = 1; k < `WIN_LEN; k++) begin
            rr = r + k * dr;
            cc = c + k * dc;
            if (go && rr >= 0 && rr < `BOARD_N && cc >= 0 && cc < `BOARD_N) begin
                if (b[rr * `BOARD_N + cc] == s) begin
                    n++;
                end else begin
                    go = 1'b0;
                end
            end else begin
                go = 1'b0;
            end
        end
        return n;
    endfunction

    function automatic int longest_line(input board_pkg::board_t b, input int r, input int c,
                                        input board_pkg::cell_t s);
        int best;
        int n;
        int dr;
        int dc;
        best = 0;
        for (int d = 0; d < 4; d++) begin
            dr = (d == 0) ? 0 : 1;
            dc = (d == 0) ? 1 : (d == 1) ? 0 : (d == 2) ? 1 : -1;
            n = 1 + count_ray(b, r, c, dr, dc, s) + count_ray(b, r, c, -dr, -dc, s);
            if (n > best) begin
                best = n;
            end
        end
        return best;
    endfunction

    task automatic model_node(input logic [4:0] depth, input int lr, input int lc);
        board_pkg::cell_t stone;
        board_pkg::cell_t mover;
        stone = bd[lr * `BOARD_N + lc];
        mover = depth[0] ? board_pkg::OURS : board_pkg::THEIRS;
        mdl_win = (stone != board_pkg::EMPTY) && (longest_line(bd, lr, lc, stone) >= `WIN_LEN);
        mdl_win_us = (stone == board_pkg::OURS);
        mdl_full = 0;
        exp_row.delete();
        exp_col.delete();
        for (int r = 0; r < `BOARD_N; r++) begin
            for (int c = 0; c < `BOARD_N; c++) begin
                if (bd[r * `BOARD_N + c] == board_pkg::EMPTY &&
                    longest_line(bd, r, c, mover) >= `THREAT_LEN) begin
                    mdl_full++;
                    if (exp_row.size() < `MAX_CAND) begin
                        exp_row.push_back(r);
                        exp_col.push_back(c);
                    end
                end
            end
        end
    endtask

    task automatic run_node(input logic [4:0] depth, input int lr, input int lc,
                            input bit slow, input string name);
        board_pkg::board_t kid;
        board_pkg::cell_t  mover;
        bit                exp_res;
        int                exp_kids;
        int                lat;
        int                delay;
        int                k;
        bit                done;
        model_node(depth, lr, lc);
        mover = depth[0] ? board_pkg::OURS : board_pkg::THEIRS;
        exp_res = ~depth[0];
        exp_kids = 0;
        if (mdl_win) begin
            exp_res = mdl_win_us;
        end else begin
            exp_kids = exp_row.size();
            // first answer equal to the mover's own wish decides
            for (k = 0; k < exp_row.size(); k++) begin
                if (child_res[k] == depth[0]) begin
                    exp_res = child_res[k];
                    exp_kids = k + 1;
                    break;
                end
            end
        end
        req_row.delete();
        req_col.delete();
        i_depth = depth;
        i_board = bd;
        i_last_row = board_pkg::coord_t'(lr);
        i_last_col = board_pkg::coord_t'(lc);
        i_start = 1'b1;
        step();
        i_start = 1'b0;
        lat = 1;
        done = 1'b0;
        while (!done) begin
            if (o_finish) begin
                done = 1'b1;
            end else if (o_child_start) begin
                k = req_row.size();
                if (k == 0) begin
                    check_eq(lat, NODE_LAT, {name, ": first child request latency"});
                end
                req_row.push_back(int'(o_child_row));
                req_col.push_back(int'(o_child_col));
                if (k < exp_row.size()) begin
                    kid = bd;
                    kid[exp_row[k] * `BOARD_N + exp_col[k]] = mover;
                    check_eq(o_child_board, kid, $sformatf("%s: child board %0d", name, k));
                end
                delay = slow ? int'($urandom % 21) : 0;
                repeat (delay + 1) step();
                i_child_done = 1'b1;
                i_child_result = (k < `MAX_CAND) ? child_res[k] : 1'b0;
                step();
                i_child_done = 1'b0;
                i_child_result = 1'b0;
                check_eq(o_child_start | o_finish, 1, {name, ": reaction to child answer"});
            end else begin
                step();
                lat++;
            end
        end
        if (req_row.size() == 0) begin
            check_eq(lat, NODE_LAT, {name, ": finish latency"});
        end
        check_eq(o_result, exp_res, {name, ": verdict"});
        check_eq(req_row.size(), exp_kids, {name, ": number of child requests"});
        for (k = 0; k < req_row.size() && k < exp_row.size(); k++) begin
            check_eq(req_row[k], exp_row[k], $sformatf("%s: request %0d row", name, k));
            check_eq(req_col[k], exp_col[k], $sformatf("%s: request %0d col", name, k));
        end
        step();
        check_eq(o_finish, 0, {name, ": finish is a single pulse"});
    endtask

    task automatic run_depth_zero(input string name);
        i_depth = 5'd0;
        i_board = bd;
        i_last_row = 5'd7;
        i_last_col = 5'd7;
        i_start = 1'b1;
        step();
        i_start = 1'b0;
        check_eq(o_finish, 1, {name, ": finish one cycle after start"});
        check_eq(o_result, 0, {name, ": verdict"});
        step();
        check_eq(o_finish, 0, {name, ": finish drops"});
    endtask

    task automatic test_reset_and_depth_zero();
        for (int k = 0; k < 4; k++) begin
            check_eq(o_finish, 0, "finish low after reset");
            check_eq(o_child_start, 0, "child start low after reset");
            check_eq(o_result, 0, "result low after reset");
            step();
        end
        bd = '0;
        place(7, 7, board_pkg::OURS);
        run_depth_zero("depth zero after reset");
    endtask

    task automatic test_win_lines();
        int sr [4] = '{7, 4, 2, 0};
        int sc [4] = '{3, 2, 2, 14};
        int lr [4] = '{7, 8, 2, 4};
        int lc [4] = '{5, 2, 2, 10};
        int dr [4] = '{0, 1, 1, 1};
        int dc [4] = '{1, 0, 1, -1};
        board_pkg::cell_t s;
        for (int who = 0; who < 2; who++) begin
            s = (who == 0) ? board_pkg::OURS : board_pkg::THEIRS;
            for (int d = 0; d < 4; d++) begin
                bd = '0;
                place_line(sr[d], sc[d], dr[d], dc[d], `WIN_LEN, s);
                // a threat of ours, so a missed win would issue a child
                place_line(14, 0, 0, 1, 3, board_pkg::OURS);
                run_node(5'd3, lr[d], lc[d], 1'b0, $sformatf("win side %0d dir %0d", who, d));
            end
        end
    endtask

    task automatic build_threat_board(input board_pkg::cell_t a, input board_pkg::cell_t b);
        bd = '0;
        place_line(3, 2, 0, 1, 3, a);
        place(3, 6, b);
        place_line(8, 10, 1, 0, 3, a);
        place(12, 3, a);
        place(12, 4, a);
        place(12, 6, a);
        place(0, 0, b);
    endtask

    task automatic test_mover_us();
        build_threat_board(board_pkg::OURS, board_pkg::THEIRS);
        child_res = '{default: 1'b0};
        child_res[2] = 1'b1;
        run_node(5'd3, 3, 4, 1'b0, "mover us fixed answers");
        for (int k = 0; k < `MAX_CAND; k++) begin
            child_res[k] = 1'($urandom % 2);
        end
        run_node(5'd3, 3, 4, 1'b1, "mover us random answers");
    endtask

    task automatic test_mover_them();
        build_threat_board(board_pkg::THEIRS, board_pkg::OURS);
        child_res = '{default: 1'b1};
        child_res[2] = 1'b0;
        run_node(5'd2, 3, 4, 1'b0, "mover them no delay");
        run_node(5'd2, 3, 4, 1'b1, "mover them random delay");
        child_res = '{default: 1'b1};
        run_node(5'd2, 3, 4, 1'b1, "mover them all children hold");
    endtask

    task automatic test_no_threats();
        bd = '0;
        place(0, 0, board_pkg::OURS);
        place(7, 7, board_pkg::THEIRS);
        place(14, 14, board_pkg::OURS);
        run_node(5'd3, 7, 7, 1'b0, "empty list mover us");
        run_node(5'd2, 0, 0, 1'b0, "empty list mover them");
        // verdict is 1 here, so depth zero has to clear it
        run_depth_zero("depth zero after a verdict of 1");
    endtask

    task automatic test_list_overflow();
        bd = '0;
        for (int r = 0; r < `BOARD_N; r += 2) begin
            place_line(r, 5, 0, 1, 3, board_pkg::OURS);
        end
        place_line(7, 10, 0, 1, 3, board_pkg::OURS);
        child_res = '{default: 1'b0};
        run_node(5'd1, 0, 5, 1'b0, "list overflow");
        check_eq(mdl_full > `MAX_CAND, 1, "overflow board holds more threats than the list");
    endtask

    initial begin
        errors = 0;
        void'($urandom(32'h7d2c));
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_depth = '0;
        i_board = '0;
        i_last_row = '0;
        i_last_col = '0;
        i_child_done = 1'b0;
        i_child_result = 1'b0;
        bd = '0;
        child_res = '{default: 1'b0};
        repeat (16) @(posedge i_clk);
        #10;
        i_rst_n = 1'b1;
        test_reset_and_depth_zero();
        test_win_lines();
        test_mover_us();
        test_mover_them();
        test_no_threats();
        test_list_overflow();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/board_pkg.sv
verilog/search_pkg.sv
verilog/board_if.sv
verilog/win_check.sv
verilog/threat_scan.sv
verilog/kill_node.sv
verilog/gomoku_kill_top.sv
bench/tb_gomoku_kill.sv

// File: Bender.yml
package:
  name: gomoku_kill

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/board_pkg.sv
      - verilog/search_pkg.sv
      - verilog/board_if.sv
      - verilog/win_check.sv
      - verilog/threat_scan.sv
      - verilog/kill_node.sv
      - verilog/gomoku_kill_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_gomoku_kill.sv
